//--- verilog/stepper_pkg.sv
// Stepper SPI shared definitions
package stepper_pkg;

  // frame and timing sizes
  localparam int spi_frame_bits  = 40;
  localparam int cs_count        = 12;
  localparam int spi_half_period = 8;

  // counter widths derived from the sizes above
  localparam int half_cnt_w = $clog2(spi_half_period);
  localparam int bit_cnt_w  = $clog2(spi_frame_bits + 1);

  // register map, one word each
  localparam logic [31:0] addr_out_upper = 32'h1000_0000;
  localparam logic [31:0] addr_out_lower = 32'h1000_0004;
  localparam logic [31:0] addr_in_upper  = 32'h1000_0008;
  localparam logic [31:0] addr_in_lower  = 32'h1000_000c;
  localparam logic [31:0] addr_config    = 32'h1000_0010;
  localparam logic [31:0] addr_status    = 32'h1000_0014;

  // one-hot register select plus hit flag
  typedef struct packed {
    logic out_upper;
    logic out_lower;
    logic in_upper;
    logic in_lower;
    logic cfg;
    logic status;
    logic hit;
  } reg_sel_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  // config word, stored raw and decoded into fields by the engine
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [26:0] unused;
      logic [3:0]  cs_sel;
      logic        send_en;
    } fields;
  } spi_config_u;

  typedef struct packed {
    logic [spi_frame_bits-1:0] tx_data;
    logic [3:0]                cs_sel;
    logic                      send_en;
  } spi_cmd_t;

  typedef struct packed {
    logic [spi_frame_bits-1:0] rx_data;
    logic                      ready;
  } spi_result_t;

  typedef struct packed {
    logic                sck;
    logic                mosi;
    logic [cs_count-1:0] cs_n;
  } spi_pins_t;

endpackage

//--- verilog/bus_decoder.sv
// Bus address decoder
`timescale 1ns/1ps

module bus_decoder
  import stepper_pkg::*;
(
  input  logic     clk_25mhz,
  input  logic     rst,
  input  bus_req_t bus_req,
  output reg_sel_t sel,
  output logic     ready
);

  reg_sel_t dec_sel;
  logic     captured;
  logic     acked;

  // compare the address against the register map
  always_comb begin
    dec_sel = '0;
    case (bus_req.addr)
      addr_out_upper: dec_sel.out_upper = 1'b1;
      addr_out_lower: dec_sel.out_lower = 1'b1;
      addr_in_upper:  dec_sel.in_upper  = 1'b1;
      addr_in_lower:  dec_sel.in_lower  = 1'b1;
      addr_config:    dec_sel.cfg       = 1'b1;
      addr_status:    dec_sel.status    = 1'b1;
      default:        dec_sel           = '0;
    endcase
    dec_sel.hit = dec_sel.out_upper | dec_sel.out_lower | dec_sel.in_upper |
                  dec_sel.in_lower | dec_sel.cfg | dec_sel.status;
  end

  // first valid cycle latches the select, the next one answers
  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      sel      <= '0;
      ready    <= 1'b0;
      captured <= 1'b0;
      acked    <= 1'b0;
    end else if (!bus_req.valid) begin
      // request over, drop the selects
      sel      <= '0;
      ready    <= 1'b0;
      captured <= 1'b0;
      acked    <= 1'b0;
    end else begin
      if (!captured) begin
        sel      <= dec_sel;
        captured <= 1'b1;
      end
      // single pulse, even while valid is still held
      ready <= captured & ~acked;
      if (captured) begin
        acked <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/spi_io_regs.sv
// SPI register file
`timescale 1ns/1ps

module spi_io_regs
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        rst,
  input  bus_req_t    bus_req,
  input  reg_sel_t    sel,
  input  logic        ready,
  output logic [31:0] rdata,
  output spi_cmd_t    cmd,
  input  spi_result_t result
);

  logic [31:0] out_upper;
  logic [31:0] out_lower;
  spi_config_u cfg;
  logic [31:0] in_upper;
  logic [31:0] in_lower;
  logic [31:0] status;
  logic        wr_en;

  // any strobe bit writes the full word
  assign wr_en = ready && (bus_req.wstrb != 4'b0000);

  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      out_upper <= '0;
      out_lower <= '0;
      cfg.raw   <= '0;
    end else if (wr_en) begin
      if (sel.out_upper) begin
        out_upper <= bus_req.wdata;
      end
      if (sel.out_lower) begin
        out_lower <= bus_req.wdata;
      end
      if (sel.cfg) begin
        cfg.raw <= bus_req.wdata;
      end
      // in and status registers are read-only
    end
  end

  // read-only views of the engine result
  assign in_upper = {24'b0, result.rx_data[spi_frame_bits-1:32]};
  assign in_lower = result.rx_data[31:0];
  assign status   = {31'b0, result.ready};

  // readback mux, zero on a miss
  always_comb begin
    rdata = '0;
    if (sel.hit) begin
      if (sel.out_upper) begin
        rdata = out_upper;
      end else if (sel.out_lower) begin
        rdata = out_lower;
      end else if (sel.in_upper) begin
        rdata = in_upper;
      end else if (sel.in_lower) begin
        rdata = in_lower;
      end else if (sel.cfg) begin
        rdata = cfg.raw;
      end else if (sel.status) begin
        rdata = status;
      end
    end
  end

  // frame is upper[7:0] followed by the lower word
  assign cmd.tx_data = {out_upper[7:0], out_lower};
  assign cmd.cs_sel  = cfg.fields.cs_sel;
  assign cmd.send_en = cfg.fields.send_en;

endmodule

//--- verilog/spi_master.sv
// SPI shift engine
`timescale 1ns/1ps

module spi_master
  import stepper_pkg::*;
(
  input  logic        clk_25mhz,
  input  logic        rst,
  input  spi_cmd_t    cmd,
  input  logic        miso,
  output spi_result_t result,
  output spi_pins_t   pins
);

  logic                      send_en_q;
  logic                      start;
  logic                      ready_q;
  logic                      sck_q;
  logic [cs_count-1:0]       cs_n_q;
  logic [cs_count-1:0]       cs_decoded_n;
  logic [spi_frame_bits-1:0] tx_shift;
  logic [spi_frame_bits-1:0] rx_shift;
  logic [spi_frame_bits-1:0] rx_data_q;
  logic [half_cnt_w-1:0]     half_cnt;
  logic [bit_cnt_w-1:0]      bit_cnt;
  logic                      half_done;
  logic                      last_bit;

  // send_en edge detect, only honored when idle
  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      send_en_q <= 1'b0;
    end else begin
      send_en_q <= cmd.send_en;
    end
  end

  assign start = cmd.send_en && !send_en_q && ready_q;

  // one-hot active-low chip select, none for out-of-range values
  always_comb begin
    cs_decoded_n = '1;
    if (cmd.cs_sel < cs_count) begin
      cs_decoded_n[cmd.cs_sel] = 1'b0;
    end
  end

  assign half_done = (half_cnt == half_cnt_w'(spi_half_period - 1));
  assign last_bit  = (bit_cnt == bit_cnt_w'(spi_frame_bits));

  // control path: sck, cs, bit count and ready
  always_ff @(posedge clk_25mhz) begin
    if (rst) begin
      ready_q   <= 1'b1;
      sck_q     <= 1'b1;
      cs_n_q    <= '1;
      half_cnt  <= '0;
      bit_cnt   <= '0;
      tx_shift  <= '0;
      rx_data_q <= '0;
    end else if (start) begin
      ready_q  <= 1'b0;
      sck_q    <= 1'b1;
      cs_n_q   <= cs_decoded_n;
      half_cnt <= '0;
      bit_cnt  <= '0;
      tx_shift <= cmd.tx_data;
    end else if (!ready_q) begin
      if (!half_done) begin
        half_cnt <= half_cnt + 1'b1;
      end else begin
        half_cnt <= '0;
        if (sck_q && last_bit) begin
          // trailing half period done, release the bus
          cs_n_q    <= '1;
          rx_data_q <= rx_shift;
          ready_q   <= 1'b1;
        end else if (sck_q) begin
          sck_q <= 1'b0;
          // msb is already on mosi for the first bit
          if (bit_cnt != '0) begin
            tx_shift <= {tx_shift[spi_frame_bits-2:0], 1'b0};
          end
        end else begin
          sck_q   <= 1'b1;
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // miso sampled on each rising sck edge, msb first
  always_ff @(posedge clk_25mhz) begin
    if (!ready_q && half_done && !sck_q) begin
      rx_shift <= {rx_shift[spi_frame_bits-2:0], miso};
    end
  end

  assign result.rx_data = rx_data_q;
  assign result.ready   = ready_q;

  assign pins.sck  = sck_q;
  assign pins.mosi = tx_shift[spi_frame_bits-1];
  assign pins.cs_n = cs_n_q;

endmodule

//--- verilog/stepper_spi_top.sv
// Stepper SPI subsystem top
`timescale 1ns/1ps

module stepper_spi_top
  import stepper_pkg::*;
(
  input  logic      clk_25mhz,
  input  logic      rst,

  // memory bus from the cpu side
  input  bus_req_t  bus_req,
  output bus_rsp_t  bus_rsp,

  // spi lines to the stepper drivers
  input  logic      miso,
  output spi_pins_t spi_pins
);

  reg_sel_t    sel;
  logic        bus_ready;
  logic [31:0] rdata;
  spi_cmd_t    cmd;
  spi_result_t result;

  // address decode and fixed-latency ready
  bus_decoder i_bus_decoder (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .bus_req   (bus_req),
    .sel       (sel),
    .ready     (bus_ready)
  );

  // bus-visible spi registers
  spi_io_regs i_spi_io_regs (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .bus_req   (bus_req),
    .sel       (sel),
    .ready     (bus_ready),
    .rdata     (rdata),
    .cmd       (cmd),
    .result    (result)
  );

  // 40-bit shift engine
  spi_master i_spi_master (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .cmd       (cmd),
    .miso      (miso),
    .result    (result),
    .pins      (spi_pins)
  );

  assign bus_rsp.ready = bus_ready;
  assign bus_rsp.rdata = rdata;

endmodule

//--- verif/spi_slave_model.sv
// SPI device array model
`timescale 1ns/1ps

module spi_slave_model
  import stepper_pkg::*;
(
  input  logic                      rst,
  input  logic                      sck,
  input  logic                      mosi,
  input  logic [cs_count-1:0]       cs_n,
  input  logic [spi_frame_bits-1:0] reply,
  output logic                      miso,
  output logic [spi_frame_bits-1:0] frame,
  output int                        frame_count,
  output logic                      chip_seen,
  output logic [3:0]                chip_idx,
  output logic                      cs_conflict
);

  logic [spi_frame_bits-1:0] shift;
  int                        bit_cnt;
  logic                      cur_seen;
  logic [3:0]                cur_idx;

  function automatic int low_count(input logic [cs_count-1:0] lines);
    int count;
    count = 0;
    for (int i = 0; i < cs_count; i++) begin
      if (lines[i] === 1'b0) begin
        count++;
      end
    end
    return count;
  endfunction

  initial begin
    miso        = 1'b0;
    frame       = '0;
    frame_count = 0;
    chip_seen   = 1'b0;
    chip_idx    = '0;
    cs_conflict = 1'b0;
    shift       = '0;
    bit_cnt     = 0;
    cur_seen    = 1'b0;
    cur_idx     = '0;
  end

  // only one driver may be selected at a time
  always @(cs_n) begin
    if (!rst && low_count(cs_n) > 1) begin
      $display("spi model: more than one chip select is low at once");
      cs_conflict = 1'b1;
    end
  end

  // mosi sampled on the rising edge, frame published after 40 bits
  always @(posedge sck) begin
    if (!rst) begin
      shift = {shift[spi_frame_bits-2:0], mosi};
      for (int i = 0; i < cs_count; i++) begin
        if (cs_n[i] === 1'b0) begin
          cur_seen = 1'b1;
          cur_idx  = 4'(i);
        end
      end
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == spi_frame_bits) begin
        frame       = shift;
        chip_seen   = cur_seen;
        chip_idx    = cur_idx;
        frame_count = frame_count + 1;
        bit_cnt     = 0;
        cur_seen    = 1'b0;
      end
    end
  end

  // reply goes out msb first, next bit after each falling edge
  always @(negedge sck) begin
    if (!rst) begin
      miso <= reply[spi_frame_bits-1-bit_cnt];
    end
  end

endmodule

//--- verif/stepper_tb.sv
// Stepper SPI testbench
`timescale 1ns/1ps

module stepper_tb
  import stepper_pkg::*;
();

  localparam int n_transfers     = 24;
  localparam int transfer_cycles = 2 * spi_half_period * spi_frame_bits + spi_half_period;
  localparam int timeout_cycles  = n_transfers * (transfer_cycles + 200);
  localparam int clk_period      = 40;
  localparam int bus_timeout     = 8;
  localparam int poll_limit      = 400;

  logic                      clk_25mhz;
  logic                      rst;
  bus_req_t                  bus_req;
  bus_rsp_t                  bus_rsp;
  logic                      miso;
  spi_pins_t                 spi_pins;
  logic [spi_frame_bits-1:0] reply;
  logic [spi_frame_bits-1:0] frame;
  int                        frame_count;
  logic                      chip_seen;
  logic [3:0]                chip_idx;
  logic                      cs_conflict;
  logic [31:0]               lfsr_state;

  stepper_spi_top i_stepper_spi_top (
    .clk_25mhz (clk_25mhz),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .miso      (miso),
    .spi_pins  (spi_pins)
  );

  spi_slave_model i_spi_slave_model (
    .rst         (rst),
    .sck         (spi_pins.sck),
    .mosi        (spi_pins.mosi),
    .cs_n        (spi_pins.cs_n),
    .reply       (reply),
    .miso        (miso),
    .frame       (frame),
    .frame_count (frame_count),
    .chip_seen   (chip_seen),
    .chip_idx    (chip_idx),
    .cs_conflict (cs_conflict)
  );

  always #(clk_period / 2) clk_25mhz = ~clk_25mhz;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [63:0] random_bits(input int count);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // one bus cycle, ready must come 2 cycles after valid
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int cycles;
    @(posedge clk_25mhz);
    bus_req.valid <= 1'b1;
    bus_req.addr  <= addr;
    bus_req.wdata <= wdata;
    bus_req.wstrb <= wstrb;
    cycles = 0;
    do begin
      @(posedge clk_25mhz);
      cycles++;
    end while (!bus_rsp.ready && cycles < bus_timeout);
    if (!bus_rsp.ready) begin
      $display("bus ready never arrived for address 0x%08h", addr);
      $display("CHECKS FAILED");
      $fatal(1);
    end
    rdata = bus_rsp.rdata;
    check_value("bus ready latency", cycles - 1, 2);
    bus_req <= '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [3:0]  strb;
    logic [31:0] unused_rdata;
    strb = random_bits(4);
    if (strb == 4'b0000) begin
      strb = 4'b0001;
    end
    bus_access(addr, data, strb, unused_rdata);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'b0000, data);
  endtask

  task automatic check_reset_state();
    logic [31:0] rdata;
    check_value("cs_n after reset", spi_pins.cs_n, {cs_count{1'b1}});
    check_value("sck after reset", spi_pins.sck, 1'b1);
    check_value("bus ready after reset", bus_rsp.ready, 1'b0);
    bus_read(addr_status, rdata);
    check_value("status", rdata, 32'h1);
    bus_read(addr_out_upper, rdata);
    check_value("out upper", rdata, 32'h0);
    bus_read(addr_out_lower, rdata);
    check_value("out lower", rdata, 32'h0);
    bus_read(addr_in_upper, rdata);
    check_value("in upper", rdata, 32'h0);
    bus_read(addr_in_lower, rdata);
    check_value("in lower", rdata, 32'h0);
    bus_read(addr_config, rdata);
    check_value("config", rdata, 32'h0);
  endtask

  task automatic check_register_access();
    logic [31:0] data;
    logic [31:0] rdata;
    data = random_bits(32);
    bus_write(addr_out_upper, data);
    bus_read(addr_out_upper, rdata);
    check_value("out upper", rdata, data);
    data = random_bits(32);
    bus_write(addr_out_lower, data);
    bus_read(addr_out_lower, rdata);
    check_value("out lower", rdata, data);
    // send_en kept low so no transfer starts here
    data = random_bits(32) & 32'hffff_fffe;
    bus_write(addr_config, data);
    bus_read(addr_config, rdata);
    check_value("config", rdata, data);
    bus_write(addr_in_upper, random_bits(32));
    bus_read(addr_in_upper, rdata);
    check_value("in upper", rdata, 32'h0);
    bus_write(addr_in_lower, random_bits(32));
    bus_read(addr_in_lower, rdata);
    check_value("in lower", rdata, 32'h0);
    bus_write(addr_status, random_bits(32));
    bus_read(addr_status, rdata);
    check_value("status", rdata, 32'h1);
    data = {4'h2, 26'(random_bits(26)), 2'b00};
    bus_write(data, random_bits(32));
    bus_read(data, rdata);
    check_value("unmapped rdata", rdata, 32'h0);
  endtask

  task automatic run_transfer();
    logic [31:0]               upper;
    logic [31:0]               lower;
    logic [31:0]               rdata;
    logic [spi_frame_bits-1:0] reply_word;
    logic [3:0]                cs_sel;
    spi_config_u               start_cfg;
    spi_config_u               busy_cfg;
    int                        frames_before;
    int                        polls;
    upper                    = random_bits(32);
    lower                    = random_bits(32);
    reply_word               = random_bits(spi_frame_bits);
    cs_sel                   = random_bits(4);
    start_cfg.fields.unused  = random_bits(27);
    start_cfg.fields.cs_sel  = cs_sel;
    start_cfg.fields.send_en = 1'b1;
    busy_cfg.fields.unused   = random_bits(27);
    busy_cfg.fields.cs_sel   = random_bits(4);
    busy_cfg.fields.send_en  = 1'b1;
    frames_before            = frame_count;
    bus_write(addr_out_upper, upper);
    bus_write(addr_out_lower, lower);
    reply <= reply_word;
    bus_write(addr_config, start_cfg.raw);
    bus_read(addr_status, rdata);
    check_value("status during transfer", rdata, 32'h0);
    // send_en stays high, so this rewrite is no new edge
    bus_write(addr_config, busy_cfg.raw);
    polls = 0;
    do begin
      bus_read(addr_status, rdata);
      polls++;
    end while (rdata !== 32'h1 && polls < poll_limit);
    check_value("status after transfer", rdata, 32'h1);
    check_value("cs_n after transfer", spi_pins.cs_n, {cs_count{1'b1}});
    check_value("sck after transfer", spi_pins.sck, 1'b1);
    bus_read(addr_in_lower, rdata);
    check_value("in lower", rdata, reply_word[31:0]);
    bus_read(addr_in_upper, rdata);
    check_value("in upper", rdata, {24'h0, reply_word[39:32]});
    bus_read(addr_config, rdata);
    check_value("config", rdata, busy_cfg.raw);
    check_value("frame count", frame_count, frames_before + 1);
    check_value("spi frame", frame, {upper[7:0], lower});
    if (cs_sel < cs_count) begin
      check_value("chip select seen", chip_seen, 1'b1);
      check_value("chip select index", chip_idx, cs_sel);
    end else begin
      check_value("chip select seen", chip_seen, 1'b0);
    end
    // send_en still held high, the engine must stay idle
    bus_read(addr_status, rdata);
    check_value("status with send_en held", rdata, 32'h1);
    busy_cfg.fields.send_en = 1'b0;
    bus_write(addr_config, busy_cfg.raw);
  endtask

  initial begin
    clk_25mhz   = 1'b0;
    rst         = 1'b1;
    bus_req     = '0;
    reply       = '0;
    lfsr_state  = 32'hc34f_3d4f;
    repeat (4) @(posedge clk_25mhz);
    rst <= 1'b0;
    check_reset_state();
    check_register_access();
    for (int t = 0; t < n_transfers; t++) begin
      run_transfer();
    end
    check_value("frame count", frame_count, n_transfers);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  always @(posedge cs_conflict) begin
    $display("more than one chip select was driven low at the same time");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  // watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("run timed out after %0d cycles", timeout_cycles);
    $display("CHECKS FAILED");
    $fatal(1);
  end

endmodule

//--- compile.f
verilog/stepper_pkg.sv
verilog/bus_decoder.sv
verilog/spi_io_regs.sv
verilog/spi_master.sv
verilog/stepper_spi_top.sv
verif/spi_slave_model.sv
verif/stepper_tb.sv
